//--- t08_mem_defines.svh
// **************************************************
// t08 memory subsystem constants
// sizes, peripheral address and target latencies
// **************************************************
`ifndef T08_MEM_DEFINES_SVH
`define T08_MEM_DEFINES_SVH

// word RAM, 2 KiB starting at byte address 0
`define T08_RAM_WORDS 512

// mailbox byte address, word aligned
`define T08_PERIPH_ADDR 32'd923920

// cycles from sel to ack, both must be at least 1
`define T08_RAM_WAIT 1
`define T08_PERIPH_WAIT 4

`endif

//--- t08_mem_pkg.sv
// **************************************************
// t08 memory package
// load/store width codes and the request and
// response structs shared by handler, bus and targets
// **************************************************
package t08_mem_pkg;

    // same encoding as RISC-V func3
    typedef enum logic [2:0] {
        lb  = 3'd0,
        lh  = 3'd1,
        lw  = 3'd2,
        lbu = 3'd4,
        lhu = 3'd5
    } mem_width_e;

    // store codes share the load values
    localparam mem_width_e sb = lb;
    localparam mem_width_e sh = lh;
    localparam mem_width_e sw = lw;

    // data access requested by the core for one instruction
    typedef struct packed {
        logic        load;
        logic        store;
        mem_width_e  width;
        logic [31:0] addr;
        logic [31:0] wdata;
    } core_data_op_t;

    // one bus request, handler to bus and bus to targets
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;    // byte lane enables
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

//--- t08_data_ram.sv
// **************************************************
// t08 data RAM
// word memory with byte enables, ack after a fixed
// number of wait cycles
// **************************************************
`timescale 1ns/1ps
`include "t08_mem_defines.svh"

module t08_data_ram (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   sel,
    input  t08_mem_pkg::mem_req_t  bus_req,
    output logic                   ack,
    output logic [31:0]            rdata
);
    import t08_mem_pkg::*;

    localparam int AW = $clog2(`T08_RAM_WORDS);

    logic [31:0]   mem [`T08_RAM_WORDS];
    logic [AW-1:0] idx;
    logic [7:0]    wait_cnt;

    assign idx = bus_req.addr[AW+1:2];  // word index, byte offset dropped

    // counts down from the wait value, ack on the last step
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst)
            wait_cnt <= '0;
        else if (sel)
            wait_cnt <= 8'(`T08_RAM_WAIT);
        else if (wait_cnt != '0)
            wait_cnt <= wait_cnt - 8'd1;
    end

    assign ack = (wait_cnt == 8'd1);

    always_ff @(posedge clk) begin
        if (sel) begin
            if (bus_req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_req.be[b])
                        mem[idx][8*b +: 8] <= bus_req.wdata[8*b +: 8];
                end
            end
            rdata <= mem[idx];  // old word on a write, unused then
        end
    end

endmodule

//--- t08_periph_mailbox.sv
// **************************************************
// t08 peripheral mailbox
// data register and write count, slow response
// **************************************************
`timescale 1ns/1ps
`include "t08_mem_defines.svh"

module t08_periph_mailbox (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   sel,
    input  t08_mem_pkg::mem_req_t  bus_req,
    output logic                   ack,
    output logic [31:0]            rdata
);
    import t08_mem_pkg::*;

    logic [31:0] data_reg;
    logic [7:0]  wr_count;  // wraps after 255 writes
    logic [7:0]  wait_cnt;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            data_reg <= '0;
            wr_count <= '0;
            wait_cnt <= '0;
        end else begin
            if (sel && bus_req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_req.be[b])
                        data_reg[8*b +: 8] <= bus_req.wdata[8*b +: 8];
                end
                wr_count <= wr_count + 8'd1;
            end
            if (sel)
                wait_cnt <= 8'(`T08_PERIPH_WAIT);
            else if (wait_cnt != '0)
                wait_cnt <= wait_cnt - 8'd1;
        end
    end

    assign ack   = (wait_cnt == 8'd1);
    assign rdata = {wr_count, data_reg[23:0]}; // count overlays top byte

endmodule

//--- t08_mem_bus.sv
// **************************************************
// t08 memory bus
// decodes each request to RAM, mailbox or the
// unmapped responder and returns the chosen response
// **************************************************
`timescale 1ns/1ps
`include "t08_mem_defines.svh"

module t08_mem_bus (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   req_valid,
    input  t08_mem_pkg::mem_req_t  req,
    input  logic                   ram_ack,
    input  logic [31:0]            ram_rdata,
    input  logic                   mbox_ack,
    input  logic [31:0]            mbox_rdata,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output t08_mem_pkg::mem_rsp_t  rsp,
    output logic                   ram_sel,
    output logic                   mbox_sel,
    output t08_mem_pkg::mem_req_t  bus_req
);
    import t08_mem_pkg::*;

    typedef enum logic [1:0] {
        tgt_ram,
        tgt_mbox,
        tgt_none
    } target_e;

    localparam logic [31:0] RAM_LIMIT = 32'(`T08_RAM_WORDS * 4);
    localparam logic [31:0] PERIPH    = `T08_PERIPH_ADDR;

    logic    busy;      // one request outstanding
    target_e tgt;       // target of the outstanding request
    target_e tgt_dec;
    logic    accept;
    logic    none_sel;  // unmapped responder strobe
    logic    none_ack;

    assign accept    = req_valid && req_ready;
    assign req_ready = !busy;

    always_comb begin
        if (req.addr < RAM_LIMIT)
            tgt_dec = tgt_ram;
        else if (req.addr[31:2] == PERIPH[31:2])
            tgt_dec = tgt_mbox;
        else
            tgt_dec = tgt_none;
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            busy     <= 1'b0;
            tgt      <= tgt_none;
            ram_sel  <= 1'b0;
            mbox_sel <= 1'b0;
            none_sel <= 1'b0;
            none_ack <= 1'b0;
        end else begin
            ram_sel  <= accept && (tgt_dec == tgt_ram);
            mbox_sel <= accept && (tgt_dec == tgt_mbox);
            none_sel <= accept && (tgt_dec == tgt_none);
            none_ack <= none_sel;   // answers one cycle after its sel
            if (accept) begin
                busy <= 1'b1;
                tgt  <= tgt_dec;
            end else if (rsp_valid) begin
                busy <= 1'b0;
            end
        end
    end

    // held for the targets until the next acceptance
    always_ff @(posedge clk) begin
        if (accept)
            bus_req <= req;
    end

    always_comb begin
        case (tgt)
            tgt_ram: begin
                rsp_valid = busy && ram_ack;
                rsp.rdata = ram_rdata;
            end
            tgt_mbox: begin
                rsp_valid = busy && mbox_ack;
                rsp.rdata = mbox_rdata;
            end
            default: begin
                rsp_valid = busy && none_ack;
                rsp.rdata = '0;         // unmapped reads as zero
            end
        endcase
    end

endmodule

//--- t08_handler.sv
// **************************************************
// t08 memory handler
// fetches the instruction, then runs the optional
// load or store and releases the core for one cycle
// **************************************************
`timescale 1ns/1ps

module t08_handler (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic [31:0]                 pc,
    input  t08_mem_pkg::core_data_op_t  data_op,
    input  logic                        req_ready,
    input  logic                        rsp_valid,
    input  t08_mem_pkg::mem_rsp_t       rsp,
    output logic                        req_valid,
    output t08_mem_pkg::mem_req_t       req,
    output logic [31:0]                 instruction,
    output logic [31:0]                 load_data,
    output logic                        freeze
);
    import t08_mem_pkg::*;

    typedef enum logic [1:0] {
        st_fetch,
        st_data,
        st_release
    } state_e;

    state_e     state;
    logic       wait_rsp;   // request accepted, response not yet back
    mem_width_e op_width;   // width latched with the data request
    logic       op_load;

    logic accept;
    logic has_data;
    logic fetch_done;
    logic data_done;
    logic start_fetch;
    logic start_data;

    function automatic logic [3:0] store_be(mem_width_e w);
        case (w)
            sb:      store_be = 4'b0001;
            sh:      store_be = 4'b0011;
            default: store_be = 4'b1111; // sw and unknown codes
        endcase
    endfunction

    // low lanes only, addr[1:0] is ignored
    function automatic logic [31:0] store_data(mem_width_e w, logic [31:0] d);
        case (w)
            sb:      store_data = {24'b0, d[7:0]};
            sh:      store_data = {16'b0, d[15:0]};
            default: store_data = d;
        endcase
    endfunction

    function automatic logic [31:0] load_ext(mem_width_e w, logic [31:0] d);
        case (w)
            lb:      load_ext = {{24{d[7]}}, d[7:0]};
            lh:      load_ext = {{16{d[15]}}, d[15:0]};
            lbu:     load_ext = {24'b0, d[7:0]};
            lhu:     load_ext = {16'b0, d[15:0]};
            default: load_ext = d;
        endcase
    endfunction

    function automatic mem_req_t fetch_req(logic [31:0] a);
        mem_req_t r;
        r.write = 1'b0;
        r.addr  = a;
        r.wdata = '0;
        r.be    = 4'b1111;
        return r;
    endfunction

    function automatic mem_req_t data_req(core_data_op_t op);
        mem_req_t r;
        r.write = op.store;
        r.addr  = op.addr;
        r.wdata = store_data(op.width, op.wdata);
        r.be    = op.store ? store_be(op.width) : 4'b1111;
        return r;
    endfunction

    assign accept     = req_valid && req_ready;
    assign has_data   = data_op.load || data_op.store;
    assign fetch_done = (state == st_fetch) && wait_rsp && rsp_valid;
    assign data_done  = (state == st_data) && wait_rsp && rsp_valid;
    // first fetch after reset, or the one that follows a release
    assign start_fetch = ((state == st_fetch) && !req_valid && !wait_rsp)
                       || (state == st_release);
    assign start_data  = fetch_done && has_data;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state       <= st_fetch;
            req_valid   <= 1'b0;
            wait_rsp    <= 1'b0;
            freeze      <= 1'b1;
            instruction <= '0;
            load_data   <= '0;
        end else begin
            if (start_fetch || start_data)
                req_valid <= 1'b1;
            else if (accept)
                req_valid <= 1'b0;

            if (accept)
                wait_rsp <= 1'b1;
            else if (rsp_valid)
                wait_rsp <= 1'b0;

            // low for the single release cycle
            freeze <= !((fetch_done && !has_data) || data_done);

            if (fetch_done)
                instruction <= rsp.rdata;
            if (data_done && op_load)
                load_data <= load_ext(op_width, rsp.rdata);

            case (state)
                st_fetch: begin
                    if (fetch_done)
                        state <= has_data ? st_data : st_release;
                end
                st_data: begin
                    if (data_done)
                        state <= st_release;
                end
                default: state <= st_fetch; // release lasts one cycle
            endcase
        end
    end

    // request payload, only meaningful while req_valid is high
    always_ff @(posedge clk) begin
        if (start_fetch) begin
            req <= fetch_req(pc);   // pc is the new one after release
        end else if (start_data) begin
            req      <= data_req(data_op);
            op_width <= data_op.width;
            op_load  <= data_op.load;
        end
    end

endmodule

//--- t08_mem_subsys.sv
// **************************************************
// t08 memory subsystem top
// handler, bus decoder, data RAM and mailbox
// **************************************************
`timescale 1ns/1ps

module t08_mem_subsys (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic [31:0]                 pc,
    input  t08_mem_pkg::core_data_op_t  data_op,
    output logic [31:0]                 instruction,
    output logic [31:0]                 load_data,
    output logic                        freeze
);
    import t08_mem_pkg::*;

    // handler to bus
    logic     req_valid;
    logic     req_ready;
    mem_req_t req;
    logic     rsp_valid;
    mem_rsp_t rsp;

    // bus to targets
    mem_req_t    bus_req;
    logic        ram_sel;
    logic        ram_ack;
    logic [31:0] ram_rdata;
    logic        mbox_sel;
    logic        mbox_ack;
    logic [31:0] mbox_rdata;

    t08_handler t08_handler_inst (
        .clk         (clk),
        .nrst        (nrst),
        .pc          (pc),
        .data_op     (data_op),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .req_valid   (req_valid),
        .req         (req),
        .instruction (instruction),
        .load_data   (load_data),
        .freeze      (freeze)
    );

    t08_mem_bus t08_mem_bus_inst (
        .clk        (clk),
        .nrst       (nrst),
        .req_valid  (req_valid),
        .req        (req),
        .ram_ack    (ram_ack),
        .ram_rdata  (ram_rdata),
        .mbox_ack   (mbox_ack),
        .mbox_rdata (mbox_rdata),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .ram_sel    (ram_sel),
        .mbox_sel   (mbox_sel),
        .bus_req    (bus_req)
    );

    t08_data_ram t08_data_ram_inst (
        .clk     (clk),
        .nrst    (nrst),
        .sel     (ram_sel),
        .bus_req (bus_req),
        .ack     (ram_ack),
        .rdata   (ram_rdata)
    );

    t08_periph_mailbox t08_periph_mailbox_inst (
        .clk     (clk),
        .nrst    (nrst),
        .sel     (mbox_sel),
        .bus_req (bus_req),
        .ack     (mbox_ack),
        .rdata   (mbox_rdata)
    );

endmodule

//--- tb_t08_mem_subsys.sv
// **************************************************
// t08 memory subsystem testbench
// core-side stimulus, reference model and checks
// **************************************************
`timescale 1ns/1ps
`include "t08_mem_defines.svh"

module tb_t08_mem_subsys;
    import t08_mem_pkg::*;

    localparam logic [31:0] UNMAPPED = 32'h0004_0000;  // above RAM and clear of the mailbox
    localparam logic [31:0] PERIPH   = `T08_PERIPH_ADDR;
    // bit 7 and bit 15 in all four combinations
    localparam logic [31:0] PATTERNS [4] = '{32'h1234_8080, 32'h5678_7f7f,
                                             32'h0000_807f, 32'hffff_7f80};

    logic          clk;
    logic          nrst;
    logic [31:0]   pc;
    core_data_op_t data_op;
    logic [31:0]   instruction;
    logic [31:0]   load_data;
    logic          freeze;

    logic [31:0] ref_ram [`T08_RAM_WORDS];  // unwritten words stay x as in the RAM
    logic [31:0] ref_mbox;
    logic [7:0]  ref_count;
    logic [31:0] exp_load;
    int errors = 0;     // errors of the running test
    int tests_pass = 0;
    int tests_fail = 0;
    int issued = 0;
    int cycles = 0;

    t08_mem_subsys t08_mem_subsys_inst (
        .clk         (clk),
        .nrst        (nrst),
        .pc          (pc),
        .data_op     (data_op),
        .instruction (instruction),
        .load_data   (load_data),
        .freeze      (freeze)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * issued + 100) begin
            $display("timeout: the core was not released after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // release lasts one cycle only
    release_once: assert property (@(posedge clk) disable iff (!nrst) !freeze |=> freeze)
        else begin
            $display("freeze stayed low for two cycles in a row at %0t", $time);
            errors++;
        end

    function automatic logic [31:0] model_word(logic [31:0] a);
        if (a < `T08_RAM_WORDS * 4)
            return ref_ram[a >> 2];
        if (a[31:2] == PERIPH[31:2])
            return {ref_count, ref_mbox[23:0]};   // count shows in the top byte
        return 32'h0;
    endfunction

    task automatic apply_store(logic [31:0] a, mem_width_e w, logic [31:0] d);
        logic [31:0] word;
        int          nbytes;
        nbytes = (w == sb) ? 1 : (w == sh) ? 2 : 4;
        if (a < `T08_RAM_WORDS * 4)
            word = ref_ram[a >> 2];
        else
            word = ref_mbox;
        for (int b = 0; b < nbytes; b++)
            word[8*b +: 8] = d[8*b +: 8];
        if (a < `T08_RAM_WORDS * 4) begin
            ref_ram[a >> 2] = word;
        end else if (a[31:2] == PERIPH[31:2]) begin
            ref_mbox  = word;
            ref_count = ref_count + 8'd1;
        end
        // unmapped stores vanish
    endtask

    function automatic logic [31:0] extend_load(mem_width_e w, logic [31:0] d);
        case (w)
            lb:      return 32'($signed(d[7:0]));
            lh:      return 32'($signed(d[15:0]));
            lbu:     return 32'(d[7:0]);
            lhu:     return 32'(d[15:0]);
            default: return d;
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp)
        else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic wait_release();
        @(negedge clk);
        while (freeze !== 1'b0)
            @(negedge clk);
    endtask

    // called in a release cycle and returns in the next one
    task automatic execute(logic [31:0] next_pc, logic ld, logic st, mem_width_e w,
                           logic [31:0] a, logic [31:0] d);
        logic [31:0] exp_instr;
        exp_instr = model_word(next_pc);  // fetch comes before the store
        pc        = next_pc;
        data_op   = '{load: ld, store: st, width: w, addr: a, wdata: d};
        issued++;
        if (ld)
            exp_load = extend_load(w, model_word(a));
        if (st)
            apply_store(a, w, d);
        wait_release();
        check_value("instruction", exp_instr, instruction);
        check_value("load_data", exp_load, load_data);
    endtask

    task automatic close_test(string name);
        if (errors == 0) begin
            tests_pass++;
            $display("test %s finished without errors", name);
        end else begin
            tests_fail++;
            $display("test %s finished with %0d errors", name, errors);
        end
        errors = 0;
    endtask

    initial begin
        logic [31:0] addr;
        clk       = 1'b0;
        nrst      = 1'b0;
        pc        = UNMAPPED;
        data_op   = '0;
        ref_mbox  = '0;
        ref_count = '0;
        exp_load  = '0;
        void'($urandom(22));
        repeat (3) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        assert (freeze === 1'b1)
        else begin
            $display("freeze is not high after reset");
            errors++;
        end
        wait_release();
        for (int i = 0; i < 4; i++)
            execute(UNMAPPED + 4 * i, 1'b0, 1'b0, lw, 32'h0, 32'h0);
        close_test("reset_release");

        for (int i = 0; i < 6; i++) begin
            addr = $urandom_range(`T08_RAM_WORDS - 1, 0) * 4;
            execute(UNMAPPED, 1'b0, 1'b1, sw, addr, $urandom());
            execute(UNMAPPED, 1'b0, 1'b1, sb, addr, $urandom());
            execute(UNMAPPED, 1'b1, 1'b0, lw, addr, 32'h0);
            execute(UNMAPPED, 1'b0, 1'b1, sh, addr, $urandom());
            execute(UNMAPPED, 1'b1, 1'b0, lw, addr, 32'h0);
            execute(addr, 1'b0, 1'b0, lw, 32'h0, 32'h0);   // fetch from the stored word
        end
        close_test("ram_store_load");

        for (int i = 0; i < 4; i++) begin
            execute(UNMAPPED, 1'b0, 1'b1, sw, 32'h100, PATTERNS[i]);
            execute(UNMAPPED, 1'b1, 1'b0, lb, 32'h100, 32'h0);
            execute(UNMAPPED, 1'b1, 1'b0, lh, 32'h100, 32'h0);
            execute(UNMAPPED, 1'b1, 1'b0, lbu, 32'h100, 32'h0);
            execute(UNMAPPED, 1'b1, 1'b0, lhu, 32'h100, 32'h0);
            execute(UNMAPPED, 1'b0, 1'b0, lw, 32'h0, 32'h0); // load_data must hold
        end
        close_test("load_extend");

        execute(UNMAPPED, 1'b0, 1'b1, sw, PERIPH, $urandom());
        execute(UNMAPPED, 1'b1, 1'b0, lw, PERIPH, 32'h0);
        execute(UNMAPPED, 1'b0, 1'b1, sb, PERIPH, $urandom());
        execute(UNMAPPED, 1'b1, 1'b0, lw, PERIPH, 32'h0);
        execute(UNMAPPED, 1'b0, 1'b1, sh, PERIPH, $urandom());
        execute(UNMAPPED, 1'b1, 1'b0, lw, PERIPH, 32'h0);
        close_test("mailbox");

        execute(UNMAPPED, 1'b1, 1'b0, lw, UNMAPPED + 32'h100, 32'h0);
        execute(UNMAPPED, 1'b0, 1'b1, sw, UNMAPPED + 32'h100, $urandom());
        execute(UNMAPPED, 1'b1, 1'b0, lw, PERIPH, 32'h0);
        execute(UNMAPPED, 1'b1, 1'b0, lw, 32'h100, 32'h0);
        repeat (2) @(negedge clk);  // freeze must be back high after the last release
        close_test("unmapped");

        $display("tests passed %0d failed %0d", tests_pass, tests_fail);
        if (tests_fail == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
t08_mem_pkg.sv
t08_data_ram.sv
t08_periph_mailbox.sv
t08_mem_bus.sv
t08_handler.sv
t08_mem_subsys.sv
tb_t08_mem_subsys.sv
